// File: run_sim.sh
#!/bin/sh
# build and run the load store unit testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module lsu_tb -f sources.f -o lsu_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/lsu_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1

// File: sources.f
src/lsu_pkg.sv
src/lsu_store_align.sv
src/lsu_load_align.sv
src/lsu_bus_ctrl.sv
src/lsu_top.sv
test/lsu_tb.sv

// File: src/lsu_bus_ctrl.sv
/*
 * Bus controller of the load store unit.
 * Two state request/response FSM. Drives the bus request, the ex
 * and wb stage ready signals and the busy flag.
 */

`timescale 1ns/1ps

module lsu_bus_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic data_req_ex_i,    // access pending in ex
  input  logic data_gnt_i,       // address phase accepted
  input  logic data_rvalid_i,    // response phase done
  output logic data_req_o,
  output logic lsu_ready_ex_o,   // low while waiting for a grant
  output logic lsu_ready_wb_o,   // low while waiting for a response
  output logic busy_o
);

  logic waiting_q;   // 0 idle, 1 waiting for rvalid
  logic waiting_d;

  always_comb
  begin
    waiting_d      = waiting_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    if (!waiting_q)
    begin
      // idle, pass the core request straight to the bus
      data_req_o = data_req_ex_i;
      if (data_req_ex_i)
      begin
        lsu_ready_ex_o = data_gnt_i;   // stall ex until granted
        if (data_gnt_i)
          waiting_d = 1'b1;
      end
    end
    else
    begin
      lsu_ready_wb_o = 1'b0;
      if (data_rvalid_i)
      begin
        // response done, the next access may go out in this same cycle
        lsu_ready_wb_o = 1'b1;
        data_req_o     = data_req_ex_i;
        waiting_d      = 1'b0;
        if (data_req_ex_i)
        begin
          lsu_ready_ex_o = data_gnt_i;
          waiting_d      = data_gnt_i;   // back to idle if not granted
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      waiting_q <= 1'b0;
    else
      waiting_q <= waiting_d;
  end

  assign busy_o = waiting_q || data_req_o;

  ////////////////////////////////////////////////////////////////////////////
  // bus protocol checks
  ////////////////////////////////////////////////////////////////////////////

  // only one outstanding transfer, a new grant needs the old response
  a_gnt_needs_rvalid: assert property (
    @(posedge clk) disable iff (!rst_n)
    (waiting_q && data_gnt_i) |-> data_rvalid_i
  ) else $error("grant while the previous response is still open");

  a_no_idle_rvalid: assert property (
    @(posedge clk) disable iff (!rst_n)
    !waiting_q |-> !data_rvalid_i
  ) else $error("response with no transfer outstanding");

endmodule

// File: src/lsu_load_align.sv
/*
 * Load side of the load store unit.
 * Keeps the access attributes of the granted transfer, extracts
 * bytes and halfwords from the response word, joins the two halves
 * of a split access and holds the last load result.
 */

`timescale 1ns/1ps

module lsu_load_align (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  input  logic                       data_we_ex_i,
  input  logic [lsu_pkg::TYPE_W-1:0] data_type_ex_i,
  input  logic [1:0]                 data_sign_ext_ex_i,    // fill mode
  input  logic [lsu_pkg::OFFS_W-1:0] addr_offs_i,           // from the store side adder
  input  logic                       data_misaligned_ex_i,  // split access, second phase in ex
  input  logic                       data_misaligned_i,     // split access, first phase seen
  input  logic [lsu_pkg::XLEN-1:0]   data_rdata_i,
  output logic [lsu_pkg::XLEN-1:0]   data_rdata_ex_o
);

  import lsu_pkg::*;

  // attributes of the transfer in its response phase
  logic [TYPE_W-1:0] type_q;
  logic [OFFS_W-1:0] offs_q;
  logic [1:0]        fill_q;
  logic              we_q;
  logic              split_q;   // first phase of a split access

  logic [XLEN-1:0]   rdata_q;   // raw first half or finished result
  lsu_word_u         rdata_w;   // fresh response word
  lsu_word_u         held_w;    // held word, low part of a split access
  logic [XLEN-1:0]   word_sel;
  logic [15:0]       half_sel;
  logic [7:0]        byte_sel;
  logic [XLEN-1:0]   rdata_ext;

  // upper bit pattern for a given fill mode
  function automatic logic fill_bit(input logic msb, input logic [1:0] mode);
    case (mode)
      FILL_ZERO: fill_bit = 1'b0;
      FILL_ONES: fill_bit = 1'b1;
      FILL_SIGN: fill_bit = msb;
      default:   fill_bit = msb;   // unused code, treated as sign
    endcase
  endfunction

  // capture at grant, used when the response comes back
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      type_q  <= TYPE_WORD;
      offs_q  <= '0;
      fill_q  <= FILL_ZERO;
      we_q    <= 1'b0;
      split_q <= 1'b0;
    end
    else if (data_gnt_i)
    begin
      type_q  <= data_type_ex_i;
      offs_q  <= addr_offs_i;
      fill_q  <= data_sign_ext_ex_i;
      we_q    <= data_we_ex_i;
      split_q <= data_misaligned_i;
    end
  end

  assign rdata_w = data_rdata_i;
  assign held_w  = rdata_q;

  ////////////////////////////////////////////////////////////////////////////
  // lane selection
  ////////////////////////////////////////////////////////////////////////////

  // word, offset 0 is aligned, others join with the held low part
  always_comb
  begin
    case (offs_q)
      2'd0:    word_sel = rdata_w;
      2'd1:    word_sel = {rdata_w.bytes[0], held_w.bytes[3:1]};
      2'd2:    word_sel = {rdata_w.halves[0], held_w.halves[1]};
      default: word_sel = {rdata_w.bytes[2:0], held_w.bytes[3]};
    endcase
  end

  // halfword, offset 3 spans both responses
  always_comb
  begin
    case (offs_q)
      2'd0:    half_sel = rdata_w.halves[0];
      2'd1:    half_sel = {rdata_w.bytes[2], rdata_w.bytes[1]};   // odd, straddles lanes
      2'd2:    half_sel = rdata_w.halves[1];
      default: half_sel = {rdata_w.bytes[0], held_w.bytes[3]};
    endcase
  end

  assign byte_sel = rdata_w.bytes[offs_q];

  // size select and fill
  always_comb
  begin
    case (type_q)
      TYPE_WORD: rdata_ext = word_sel;
      TYPE_HALF: rdata_ext = {{(XLEN-16){fill_bit(half_sel[15], fill_q)}}, half_sel};
      TYPE_BYTE: rdata_ext = {{(XLEN-8){fill_bit(byte_sel[7], fill_q)}}, byte_sel};
      default:   rdata_ext = {{(XLEN-8){fill_bit(byte_sel[7], fill_q)}}, byte_sel};
    endcase
  end

  // held word, raw during a first split phase so the second can join it
  always_ff @(posedge clk)
  begin
    if (data_rvalid_i && !we_q)
    begin
      if (split_q)
        rdata_q <= data_rdata_i;
      else
        rdata_q <= rdata_ext;
    end
  end

  // fresh result in the response cycle, held value afterwards
  assign data_rdata_ex_o = (data_rvalid_i && !we_q) ? rdata_ext : rdata_q;

endmodule

// File: src/lsu_pkg.sv
/*
 * Load store unit shared definitions.
 * Bus and word widths, access type codes, load fill modes
 * and the word view used by the load data extraction.
 */

package lsu_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int XLEN   = 32;          // data and address width
  localparam int NBYTES = XLEN / 8;    // byte lanes per bus word
  localparam int OFFS_W = 2;           // byte offset inside a word
  localparam int TYPE_W = 2;           // access type code width

  ////////////////////////////////////////////////////////////////////////////
  // access type codes, code 3 behaves as a byte
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [TYPE_W-1:0] TYPE_WORD = 2'd0;
  localparam logic [TYPE_W-1:0] TYPE_HALF = 2'd1;
  localparam logic [TYPE_W-1:0] TYPE_BYTE = 2'd2;

  // load fill modes for the upper bits of a byte or halfword result
  localparam logic [1:0] FILL_ZERO = 2'd0;   // zero extension
  localparam logic [1:0] FILL_SIGN = 2'd1;   // sign extension, also code 3
  localparam logic [1:0] FILL_ONES = 2'd2;   // fill with ones

  // one bus word seen either as byte lanes or as halfword lanes
  typedef union packed {
    logic [NBYTES-1:0][7:0] bytes;     // lane 0 is the lowest address
    logic [1:0][15:0]       halves;    // aligned halfwords at offset 0 and 2
  } lsu_word_u;

endpackage

// File: src/lsu_store_align.sv
/*
 * Store side of the load store unit.
 * Forms the access address, detects word and halfword accesses
 * that cross a word boundary, generates byte enables for both
 * phases and rotates the store data into its byte lanes.
 */

`timescale 1ns/1ps

module lsu_store_align (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       data_req_ex_i,         // access request from ex
  input  logic [lsu_pkg::TYPE_W-1:0] data_type_ex_i,        // word, half or byte
  input  logic [lsu_pkg::XLEN-1:0]   operand_a_ex_i,        // base register
  input  logic [lsu_pkg::XLEN-1:0]   operand_b_ex_i,        // immediate offset
  input  logic                       addr_useincr_ex_i,     // a + b when set, else a
  input  logic [lsu_pkg::XLEN-1:0]   data_wdata_ex_i,       // unaligned store data
  input  logic                       data_misaligned_ex_i,  // second phase of a split access
  output logic [lsu_pkg::XLEN-1:0]   data_addr_o,
  output logic [lsu_pkg::OFFS_W-1:0] addr_offs_o,           // byte offset, to load side
  output logic [lsu_pkg::NBYTES-1:0] data_be_o,
  output logic [lsu_pkg::XLEN-1:0]   data_wdata_o,
  output logic                       data_misaligned_o      // first phase needs a second one
);

  import lsu_pkg::*;

  logic [XLEN-1:0]   addr_int;
  logic [OFFS_W-1:0] offs;
  logic [NBYTES-1:0] be_base;     // lane pattern at offset 0
  logic [2*XLEN-1:0] wdata_dbl;   // doubled word for the rotation

  // address generation
  assign addr_int = addr_useincr_ex_i ? (operand_a_ex_i + operand_b_ex_i) : operand_a_ex_i;
  assign offs     = addr_int[OFFS_W-1:0];

  // split detection, only for a first phase
  always_comb
  begin
    data_misaligned_o = 1'b0;
    if (data_req_ex_i && !data_misaligned_ex_i)
    begin
      case (data_type_ex_i)
        TYPE_WORD: data_misaligned_o = (offs != '0);   // any nonzero offset spills
        TYPE_HALF: data_misaligned_o = (&offs);        // only offset 3 spills
        default:   data_misaligned_o = 1'b0;           // bytes never cross
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    case (data_type_ex_i)
      TYPE_WORD: be_base = 4'b1111;
      TYPE_HALF: be_base = 4'b0011;
      default:   be_base = 4'b0001;
    endcase
  end

  // first phase takes the lanes from the offset upward, the shift drops
  // whatever lands above lane 3. second phase takes the leftover low lanes
  always_comb
  begin
    if (!data_misaligned_ex_i)
      data_be_o = be_base << offs;
    else if (data_type_ex_i == TYPE_WORD)
      data_be_o = ~(be_base << offs);   // offset 1..3 gives 0001, 0011, 0111
    else
      data_be_o = 4'b0001;              // halfword tail is a single byte
  end

  // rotate left by the offset in bytes, upper half of the doubled word
  assign wdata_dbl    = {data_wdata_ex_i, data_wdata_ex_i} << {offs, 3'b000};
  assign data_wdata_o = wdata_dbl[2*XLEN-1:XLEN];

  assign data_addr_o = addr_int;
  assign addr_offs_o = offs;

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  // operands from the register file must be resolved once a request is up
  a_addr_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    data_req_ex_i |-> !$isunknown(data_addr_o)
  ) else $error("request with unknown address %h", data_addr_o);

endmodule

// File: src/lsu_top.sv
/*
 * Load store unit top level.
 * Joins the store side, the load side and the bus controller
 * between the execute stage and the data bus.
 */

`timescale 1ns/1ps

module lsu_top (
  input  logic                       clk,
  input  logic                       rst_n,

  // data bus
  output logic                       data_req_o,
  input  logic                       data_gnt_i,
  input  logic                       data_rvalid_i,
  output logic [lsu_pkg::XLEN-1:0]   data_addr_o,
  output logic                       data_we_o,
  output logic [lsu_pkg::NBYTES-1:0] data_be_o,
  output logic [lsu_pkg::XLEN-1:0]   data_wdata_o,
  input  logic [lsu_pkg::XLEN-1:0]   data_rdata_i,

  // execute stage
  input  logic                       data_req_ex_i,
  input  logic                       data_we_ex_i,
  input  logic [lsu_pkg::TYPE_W-1:0] data_type_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]   data_wdata_ex_i,
  input  logic [1:0]                 data_sign_ext_ex_i,   // fill mode for loads
  output logic [lsu_pkg::XLEN-1:0]   data_rdata_ex_o,
  input  logic [lsu_pkg::XLEN-1:0]   operand_a_ex_i,
  input  logic [lsu_pkg::XLEN-1:0]   operand_b_ex_i,
  input  logic                       addr_useincr_ex_i,
  input  logic                       data_misaligned_ex_i, // core repeats for the second half
  output logic                       data_misaligned_o,    // to the controller
  output logic                       lsu_ready_ex_o,
  output logic                       lsu_ready_wb_o,
  output logic                       busy_o
);

  import lsu_pkg::*;

  logic [OFFS_W-1:0] addr_offs;   // byte offset of the current access

  lsu_store_align u_store (
    .clk                  (clk),
    .rst_n                (rst_n),
    .data_req_ex_i        (data_req_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .operand_a_ex_i       (operand_a_ex_i),
    .operand_b_ex_i       (operand_b_ex_i),
    .addr_useincr_ex_i    (addr_useincr_ex_i),
    .data_wdata_ex_i      (data_wdata_ex_i),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_addr_o          (data_addr_o),
    .addr_offs_o          (addr_offs),
    .data_be_o            (data_be_o),
    .data_wdata_o         (data_wdata_o),
    .data_misaligned_o    (data_misaligned_o)
  );

  lsu_load_align u_load (
    .clk                  (clk),
    .rst_n                (rst_n),
    .data_gnt_i           (data_gnt_i),
    .data_rvalid_i        (data_rvalid_i),
    .data_we_ex_i         (data_we_ex_i),
    .data_type_ex_i       (data_type_ex_i),
    .data_sign_ext_ex_i   (data_sign_ext_ex_i),
    .addr_offs_i          (addr_offs),
    .data_misaligned_ex_i (data_misaligned_ex_i),
    .data_misaligned_i    (data_misaligned_o),
    .data_rdata_i         (data_rdata_i),
    .data_rdata_ex_o      (data_rdata_ex_o)
  );

  lsu_bus_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .data_req_ex_i  (data_req_ex_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .busy_o         (busy_o)
  );

  assign data_we_o = data_we_ex_i;   // write enable rides with the address phase

endmodule

// File: test/lsu_cases.txt
# we type fill operand_a operand_b useincr wdata exp_be exp_misaligned exp_rdata (hex)
# type 0 word 1 half 2/3 byte, fill 0 zero 1 sign 2 ones 3 sign, be and rdata of phase one
1 0 0 00000000 00000000 0 8a7b6c5d f 0 00000000
1 0 0 00000004 00000000 0 11223344 f 0 00000000
1 1 0 00000004 00000002 1 abcde0f1 c 0 00000000
1 2 0 00000005 00000000 0 000000c7 2 0 00000000
1 0 0 00000008 00000000 0 7f80ff01 f 0 00000000
1 2 0 00000008 00000003 1 00000099 8 0 00000000
0 0 0 00000000 00000000 0 00000000 f 0 8a7b6c5d
0 0 0 00000004 00000000 0 00000000 f 0 e0f1c744
0 2 0 00000000 00000000 0 00000000 1 0 0000005d
0 2 1 00000001 00000000 0 00000000 2 0 0000006c
0 2 2 00000000 00000002 1 00000000 4 0 ffffff7b
0 2 1 00000003 00000000 0 00000000 8 0 ffffff8a
0 3 0 0000000a 00000000 0 00000000 4 0 00000080
0 3 3 00000008 00000003 1 00000000 8 0 ffffff99
0 1 1 00000000 00000000 0 00000000 3 0 00006c5d
0 1 0 00000001 00000000 0 00000000 6 0 00007b6c
0 1 1 00000002 00000000 0 00000000 c 0 ffff8a7b
0 1 0 00000004 00000000 0 00000000 3 0 0000c744
0 1 2 00000005 00000000 0 00000000 6 0 fffff1c7
1 0 0 0000000c 00000001 1 deadbeef e 1 00000000
1 0 0 00000016 00000000 0 01234567 c 1 00000000
1 0 0 0000001c 00000003 1 cafef00d 8 1 00000000
1 1 0 00000027 00000000 0 00005aa5 8 1 00000000
0 0 0 0000000c 00000000 0 00000000 f 0 adbeefd3
0 0 0 00000010 00000000 0 00000000 f 0 a4b4c4de
0 0 0 00000014 00000000 0 00000000 f 0 4567c5d5
0 0 0 00000018 00000000 0 00000000 f 0 a6b60123
0 0 0 0000000c 00000001 1 00000000 e 1 deadbeef
0 0 0 00000016 00000000 0 00000000 c 1 01234567
0 0 1 0000001c 00000003 1 00000000 8 1 cafef00d
0 1 2 00000027 00000000 0 00000000 8 1 ffff5aa5
0 1 1 0000000f 00000000 0 00000000 8 1 ffffdead
0 1 0 0000001c 00000003 1 00000000 8 1 0000f00d

// File: test/lsu_tb.sv
/*
 * Testbench for the load store unit.
 * Plays the accesses from the case file against a small bus memory
 * with random grant and response delays, splits misaligned accesses
 * into two phases and checks lanes, addresses and load results.
 */

`timescale 1ns/1ps

module lsu_tb;

  import lsu_pkg::*;

  localparam int CLK_PERIOD = 40;
  localparam int MAX_CASES  = 64;
  localparam int HS_LIMIT   = 8;    // cycles allowed for one grant or response wait

  logic clk = 1'b0;
  logic rst_n;

  logic        data_req_o, data_gnt_i, data_rvalid_i, data_we_o;
  logic [31:0] data_addr_o, data_wdata_o, data_rdata_i;
  logic [3:0]  data_be_o;
  logic        data_req_ex_i, data_we_ex_i, addr_useincr_ex_i, data_misaligned_ex_i;
  logic [1:0]  data_type_ex_i, data_sign_ext_ex_i;
  logic [31:0] data_wdata_ex_i, operand_a_ex_i, operand_b_ex_i, data_rdata_ex_o;
  logic        data_misaligned_o, lsu_ready_ex_o, lsu_ready_wb_o, busy_o;

  logic [31:0] mem [16];                    // bus memory, one word per index
  logic [31:0] case_tab [MAX_CASES][10];    // one row per line of the case file
  int          n_cases = 0;
  int          n_mismatch = 0;
  int          n_fail = 0;
  logic [31:0] rng_state = 32'd16;

  // fields of the case being played
  int          cur_idx;
  logic        cur_we, cur_incr, cur_mis;
  logic [1:0]  cur_type, cur_fill;
  logic [31:0] cur_a, cur_b, cur_wdata, cur_res;
  logic [3:0]  cur_be;

  lsu_top u_dut (.*);

  always #(CLK_PERIOD/2) clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // uniform-ish value in 0 .. range-1
  function automatic int next_rand(input logic [31:0] range);
    rng_state = xorshift32(rng_state);
    return int'(rng_state % range);
  endfunction

  // store data moves left by the byte offset, wrapping at lane 3
  function automatic logic [31:0] rotate_bytes(input logic [31:0] w, input logic [1:0] offs);
    logic [31:0] r;
    int          dst;
    r = '0;
    for (int l = 0; l < 4; l++)
    begin
      dst = (l + int'(offs)) % 4;
      r[8*dst +: 8] = w[8*l +: 8];
    end
    return r;
  endfunction

  // low lanes left over for the second phase of a split access
  function automatic logic [3:0] tail_lanes(input logic [1:0] typ, input logic [1:0] offs);
    int nb;
    int rest;
    nb   = (typ == TYPE_WORD) ? 4 : (typ == TYPE_HALF) ? 2 : 1;
    rest = nb - (4 - int'(offs));   // bytes that did not fit above the offset
    if (rest <= 0)
      return 4'b0000;
    return 4'((1 << rest) - 1);
  endfunction

  task automatic flag_mismatch(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    n_mismatch++;
    $display("MISMATCH case %0d %s: got 0x%0h expected 0x%0h", cur_idx, name, got, exp);
  endtask

  task automatic note_failure(input string msg);
    n_fail++;
    $display("ERROR case %0d at %0t: %s", cur_idx, $time, msg);
  endtask

  // rows are ten hex fields, lines starting with # are skipped
  task automatic load_cases();
    int          fd;
    int          got;
    string       line;
    logic [31:0] f [10];
    fd = $fopen("test/lsu_cases.txt", "r");
    if (fd == 0)
      note_failure("cannot open the case file test/lsu_cases.txt");
    else
    begin
      while (!$feof(fd) && n_cases < MAX_CASES)
      begin
        got = $fgets(line, fd);
        if (got > 0 && line.len() > 0 && line[0] != "#")
        begin
          got = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9]);
          if (got == 10)
          begin
            for (int k = 0; k < 10; k++)
              case_tab[n_cases][k] = f[k];
            n_cases++;
          end
        end
      end
      $fclose(fd);
    end
    if (n_cases == 0)
      note_failure("no accesses were read from the case file");
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one bus phase, address phase then response phase
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_phase(input logic second);
    logic [31:0] a_op, addr, exp_wd;
    logic [3:0]  exp_be;
    logic        exp_mis;
    int          gd, rd, n, widx;
    a_op    = second ? cur_a + 32'd4 : cur_a;   // core steps to the next word
    addr    = cur_incr ? a_op + cur_b : a_op;
    exp_wd  = rotate_bytes(cur_wdata, addr[1:0]);
    exp_be  = second ? tail_lanes(cur_type, addr[1:0]) : cur_be;
    exp_mis = second ? 1'b0 : cur_mis;   // a second phase never splits again
    gd      = next_rand(32'd3);        // grant after 0..2 cycles
    rd      = 1 + next_rand(32'd2);    // response 1..2 cycles after grant
    n       = 0;

    @(posedge clk);
    data_req_ex_i        <= 1'b1;
    data_we_ex_i         <= cur_we;
    data_type_ex_i       <= cur_type;
    data_sign_ext_ex_i   <= cur_fill;
    operand_a_ex_i       <= a_op;
    operand_b_ex_i       <= cur_b;
    addr_useincr_ex_i    <= cur_incr;
    data_wdata_ex_i      <= cur_wdata;
    data_misaligned_ex_i <= second;
    data_gnt_i           <= (gd == 0);
    data_rvalid_i        <= 1'b0;
    data_rdata_i         <= '0;

    @(negedge clk);
    if (data_addr_o !== addr)
      flag_mismatch("data_addr_o", data_addr_o, addr);
    if (data_be_o !== exp_be)
      flag_mismatch("data_be_o", 32'(data_be_o), 32'(exp_be));
    if (data_misaligned_o !== exp_mis)
      flag_mismatch("data_misaligned_o", 32'(data_misaligned_o), 32'(exp_mis));
    if (data_we_o !== cur_we)
      flag_mismatch("data_we_o", 32'(data_we_o), 32'(cur_we));
    if (cur_we && data_wdata_o !== exp_wd)
      flag_mismatch("data_wdata_o", data_wdata_o, exp_wd);
    if (busy_o !== 1'b1)
      flag_mismatch("busy_o", 32'(busy_o), 32'd1);

    // back-pressure, request and lanes must hold until granted
    while (!lsu_ready_ex_o && n < HS_LIMIT)
    begin
      if (data_req_o !== 1'b1 || data_be_o !== exp_be)
        note_failure("request or byte enables dropped while the grant was withheld");
      n++;
      @(posedge clk);
      data_gnt_i <= (n == gd);
      @(negedge clk);
    end
    if (!(lsu_ready_ex_o && data_gnt_i && data_req_o))
      note_failure("grant handshake did not complete, or ex released without a grant");

    widx = int'(data_addr_o[5:2]);    // memory takes the access at grant
    if (data_we_o)
      for (int l = 0; l < 4; l++)
        if (data_be_o[l])
          mem[widx][8*l +: 8] = data_wdata_o[8*l +: 8];

    n = 1;
    @(posedge clk);
    data_req_ex_i <= 1'b0;   // ex moves on once granted
    data_gnt_i    <= 1'b0;
    data_rvalid_i <= (rd == 1);
    data_rdata_i  <= (rd == 1) ? mem[widx] : '0;
    @(negedge clk);
    while (!lsu_ready_wb_o && n < HS_LIMIT)
    begin
      n++;
      @(posedge clk);
      data_rvalid_i <= (n == rd);
      data_rdata_i  <= (n == rd) ? mem[widx] : '0;
      @(negedge clk);
    end
    if (!(lsu_ready_wb_o && data_rvalid_i))
      note_failure("no response seen, or wb released before the response");

    // result is due on the last phase of a load
    if (!cur_we && (second || !cur_mis) && data_rdata_ex_o !== cur_res)
      flag_mismatch("data_rdata_ex_o", data_rdata_ex_o, cur_res);
  endtask

  task automatic close_access();
    @(posedge clk);
    data_req_ex_i        <= 1'b0;
    data_misaligned_ex_i <= 1'b0;
    data_gnt_i           <= 1'b0;
    data_rvalid_i        <= 1'b0;
    data_rdata_i         <= '0;
    @(negedge clk);
    if (busy_o !== 1'b0 || lsu_ready_ex_o !== 1'b1 || lsu_ready_wb_o !== 1'b1)
      note_failure("unit not idle after the access completed");
    if (!cur_we)
    begin
      repeat (3) @(negedge clk);   // result must outlive its response cycle
      if (data_rdata_ex_o !== cur_res)
        flag_mismatch("data_rdata_ex_o (held)", data_rdata_ex_o, cur_res);
    end
  endtask

  task automatic play_case(input int i);
    cur_idx   = i;
    cur_we    = case_tab[i][0][0];
    cur_type  = case_tab[i][1][1:0];
    cur_fill  = case_tab[i][2][1:0];
    cur_a     = case_tab[i][3];
    cur_b     = case_tab[i][4];
    cur_incr  = case_tab[i][5][0];
    cur_wdata = case_tab[i][6];
    cur_be    = case_tab[i][7][3:0];
    cur_mis   = case_tab[i][8][0];
    cur_res   = case_tab[i][9];
    issue_phase(1'b0);
    if (cur_mis)
      issue_phase(1'b1);   // core repeats with the misaligned flag
    close_access();
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rst_n                <= 1'b0;
    data_gnt_i           <= 1'b0;
    data_rvalid_i        <= 1'b0;
    data_rdata_i         <= '0;
    data_req_ex_i        <= 1'b0;
    data_we_ex_i         <= 1'b0;
    data_type_ex_i       <= TYPE_WORD;
    data_sign_ext_ex_i   <= FILL_ZERO;
    data_wdata_ex_i      <= '0;
    operand_a_ex_i       <= '0;
    operand_b_ex_i       <= '0;
    addr_useincr_ex_i    <= 1'b0;
    data_misaligned_ex_i <= 1'b0;
    cur_idx = 0;
    for (int i = 0; i < 16; i++)
      mem[i] = {4'hA, 4'(i), 4'hB, 4'(i), 4'hC, 4'(i), 4'hD, 4'(i)};   // index in every byte
    load_cases();
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < n_cases; i++)
      play_case(i);
    @(negedge clk);
    $display("accesses %0d, mismatches %0d, other failures %0d", n_cases, n_mismatch, n_fail);
    if (n_mismatch == 0 && n_fail == 0)
      $display("TEST PASS");
    else
      $display("TEST FAIL");
    $finish;
  end

  initial
  begin
    wait (n_cases > 0);
    #(n_cases * 60 * CLK_PERIOD);
    $display("timeout: accesses still open after %0d cycles, the bus never finished",
             n_cases * 60);
    $display("TEST FAIL");
    $finish;
  end

endmodule
